// ==== source/div_defs.svh ====
////////////////////////////////////////
// build-time sizes of the divide unit
// include wherever a width or depth is needed
////////////////////////////////////////

`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// operand and result width
`define DIV_XLEN 32
// transaction tag width
`define DIV_TAG_W 4
// issue queue entries, equal to the issuer's starting credits
`define DIV_ISSUE_DEPTH 4
// credits granted by writeback after reset
`define DIV_WB_CREDITS 2

`endif

// ==== source/div_pkg.sv ====
////////////////////////////////////////
// shared types of the divide unit
// compile before any module that imports it
////////////////////////////////////////

`include "div_defs.svh"

package div_pkg;

  // opcode encoding
  // bit 0 selects signed operands
  // bit 1 selects the remainder instead of the quotient
  typedef enum logic [1:0] {
    OP_UDIV = 2'b00,
    OP_DIV  = 2'b01,
    OP_UREM = 2'b10,
    OP_REM  = 2'b11
  } div_op_e;

  // operand and result word
  typedef logic [`DIV_XLEN-1:0] div_word_t;

  // tag carried from issue to writeback
  typedef logic [`DIV_TAG_W-1:0] div_tag_t;

endpackage

// ==== source/lzc.sv ====
////////////////////////////////////////
// leading-zero counter built as a tree
// of two-input priority stages
////////////////////////////////////////

`timescale 1ns/1ps

module lzc #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0]         in_i,
  output logic [$clog2(WIDTH)-1:0] cnt_o,
  output logic                     empty_o
);

  localparam int CW = $clog2(WIDTH);
  localparam int NP = 2 ** CW;

  // input moved up to the msb end of a power-of-two vector
  logic [NP-1:0] pad;
  // per level valid bit and partial count of each node
  logic [NP-1:0] vld [CW+1];
  logic [CW-1:0] cnt [CW+1][NP];

  assign pad = NP'(in_i) << (NP - WIDTH);

  always_comb begin : p_tree
    for (int l = 0; l <= CW; l++) begin
      vld[l] = '0;
      for (int n = 0; n < NP; n++) begin
        cnt[l][n] = '0;
      end
    end
    // leaf node 0 holds the msb
    for (int n = 0; n < NP; n++) begin
      vld[0][n] = pad[NP-1-n];
    end
    // left child wins, otherwise skip its 2**l zeros
    for (int l = 0; l < CW; l++) begin
      for (int n = 0; n < (NP >> (l + 1)); n++) begin
        vld[l+1][n] = vld[l][2*n] | vld[l][2*n+1];
        if (vld[l][2*n]) begin
          cnt[l+1][n] = cnt[l][2*n];
        end else begin
          cnt[l+1][n] = cnt[l][2*n+1] | CW'(1 << l);
        end
      end
    end
  end

  assign cnt_o   = cnt[CW][0];
  // no one found anywhere
  assign empty_o = ~vld[CW][0];

endmodule

// ==== source/div_issue_queue.sv ====
////////////////////////////////////////
// issue queue in front of the divider
// issuer pushes against its credits, and
// every pop hands one credit back
////////////////////////////////////////

`timescale 1ns/1ps
`include "div_defs.svh"

module div_issue_queue (
  input  logic               clk_i,
  input  logic               rst_ni,
  // issue side, a valid cycle always pushes
  input  logic               push_i,
  input  div_pkg::div_op_e   op_i,
  input  div_pkg::div_word_t a_i,
  input  div_pkg::div_word_t b_i,
  input  div_pkg::div_tag_t  tag_i,
  // head toward the divider
  output logic               vld_o,
  input  logic               rdy_i,
  output div_pkg::div_op_e   op_o,
  output div_pkg::div_word_t a_o,
  output div_pkg::div_word_t b_o,
  output div_pkg::div_tag_t  tag_o,
  // one pulse per popped entry
  output logic               credit_o
);

  import div_pkg::*;

  localparam int DEPTH = `DIV_ISSUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef struct packed {
    div_op_e   op;
    div_word_t a;
    div_word_t b;
    div_tag_t  tag;
  } entry_t;

  entry_t           mem_q [DEPTH];
  entry_t           head;
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             pop;
  logic             credit_q;

  // pointer step with wrap for any depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign vld_o = (cnt_q != '0);
  assign pop   = vld_o & rdy_i;

  // head straight from the storage array
  assign head  = mem_q[rd_ptr_q];
  assign op_o  = head.op;
  assign a_o   = head.a;
  assign b_o   = head.b;
  assign tag_o = head.tag;

  assign credit_o = credit_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push_i && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!push_i && pop) begin
        cnt_q <= cnt_q - 1'b1;
      end
      // credit goes back the cycle after the pop
      credit_q <= pop;
    end
  end

  always_ff @(posedge clk_i) begin : p_mem
    if (push_i) begin
      mem_q[wr_ptr_q] <= '{op: op_i, a: a_i, b: b_i, tag: tag_i};
    end
  end

endmodule

// ==== source/serdiv.sv ====
////////////////////////////////////////
// serial integer divider
// aligns the operands by leading-zero count
// and restores one quotient bit per cycle
////////////////////////////////////////

`timescale 1ns/1ps

module serdiv #(
  parameter int WIDTH = 32
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // operation in
  input  logic              in_vld_i,
  output logic              in_rdy_o,
  input  div_pkg::div_op_e  op_i,
  input  logic [WIDTH-1:0]  a_i,
  input  logic [WIDTH-1:0]  b_i,
  input  div_pkg::div_tag_t tag_i,
  // result out
  output logic              out_vld_o,
  input  logic              out_rdy_i,
  output logic [WIDTH-1:0]  res_o,
  output div_pkg::div_tag_t tag_o
);

  import div_pkg::*;

  localparam int CW = $clog2(WIDTH);

  typedef enum logic [1:0] {
    IDLE,
    DIVIDE,
    FINISH
  } state_e;

  ////////////////////////////////////////
  // declarations
  ////////////////////////////////////////

  state_e           state_d, state_q;
  logic             load_en, step_en;

  // operand decode at load
  logic             a_neg, b_neg, b_zero, b_neg_one;
  logic [WIDTH-1:0] a_mag, b_mag;
  logic [CW-1:0]    lza, lzb;
  logic             a_empty, b_empty;
  logic [CW:0]      shift_a;
  logic [CW+1:0]    div_shift;
  logic             quo_zero;

  // loop datapath
  logic [WIDTH:0]   diff;
  logic             ge;
  logic [WIDTH-1:0] rem_q, div_q, quo_q;
  logic [WIDTH-1:0] res_mag;
  div_tag_t         tag_q;
  logic [CW-1:0]    cnt_q;

  // result flags kept for the output stage
  logic             early_q, rem_sel_q, neg_res_q, ones_q;

  ////////////////////////////////////////
  // operand alignment
  ////////////////////////////////////////

  // signed operands work on magnitudes
  assign a_neg = op_i[0] & a_i[WIDTH-1];
  assign b_neg = op_i[0] & b_i[WIDTH-1];
  assign a_mag = a_neg ? -a_i : a_i;
  assign b_mag = b_neg ? -b_i : b_i;

  lzc #(
    .WIDTH(WIDTH)
  ) i_lzc_a (
    .in_i   (a_mag),
    .cnt_o  (lza),
    .empty_o(a_empty)
  );

  lzc #(
    .WIDTH(WIDTH)
  ) i_lzc_b (
    .in_i   (b_mag),
    .cnt_o  (lzb),
    .empty_o(b_empty)
  );

  assign b_zero    = b_empty;
  assign b_neg_one = op_i[0] & (&b_i);

  // zero dividend counts as WIDTH leading zeros
  assign shift_a   = a_empty ? (CW + 1)'(WIDTH) : {1'b0, lza};
  assign div_shift = {2'b00, lzb} - {1'b0, shift_a};
  // divisor longer than dividend gives quotient 0
  assign quo_zero  = div_shift[CW+1];

  ////////////////////////////////////////
  // restoring step and output
  ////////////////////////////////////////

  // one subtractor, its borrow is the compare
  assign diff = {1'b0, rem_q} - {1'b0, div_q};
  assign ge   = ~diff[WIDTH];

  assign res_mag = rem_sel_q ? rem_q : quo_q;
  // sign fixup, divide by zero gives all ones
  assign res_o   = ones_q ? '1 : (neg_res_q ? -res_mag : res_mag);
  assign tag_o   = tag_q;

  always_comb begin : p_fsm
    state_d   = state_q;
    in_rdy_o  = 1'b0;
    out_vld_o = 1'b0;
    step_en   = 1'b0;
    unique case (state_q)
      IDLE: begin
        in_rdy_o = 1'b1;
        if (in_vld_i) begin
          state_d = DIVIDE;
        end
      end
      DIVIDE: begin
        // known results leave in the first cycle
        if (early_q) begin
          out_vld_o = 1'b1;
        end else begin
          step_en = 1'b1;
          if (cnt_q == '0) begin
            state_d = FINISH;
          end
        end
      end
      FINISH: begin
        out_vld_o = 1'b1;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
    // result taken, next operation may load right away
    if (out_vld_o && out_rdy_i) begin
      in_rdy_o = 1'b1;
      state_d  = in_vld_i ? DIVIDE : IDLE;
    end
  end

  assign load_en = in_vld_i & in_rdy_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      state_q   <= IDLE;
      cnt_q     <= '0;
      early_q   <= 1'b0;
      rem_sel_q <= 1'b0;
      neg_res_q <= 1'b0;
      ones_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (load_en) begin
        cnt_q     <= div_shift[CW-1:0];
        early_q   <= b_zero | b_neg_one | quo_zero;
        rem_sel_q <= op_i[1];
        // remainder follows the dividend sign
        neg_res_q <= op_i[1] ? a_neg : (a_neg ^ b_neg);
        ones_q    <= b_zero & ~op_i[1];
      end else if (step_en && cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_data
    if (load_en) begin
      // dividing by minus one is a plain negation
      rem_q <= b_neg_one ? '0 : a_mag;
      quo_q <= b_neg_one ? a_mag : '0;
      div_q <= b_mag << div_shift[CW-1:0];
      tag_q <= tag_i;
    end else if (step_en) begin
      if (ge) begin
        rem_q <= diff[WIDTH-1:0];
      end
      quo_q <= {quo_q[WIDTH-2:0], ge};
      div_q <= div_q >> 1;
    end
  end

endmodule

// ==== source/div_wb_port.sv ====
////////////////////////////////////////
// writeback side of the divide unit
// passes a result only while a credit is held
////////////////////////////////////////

`timescale 1ns/1ps
`include "div_defs.svh"

module div_wb_port (
  input  logic               clk_i,
  input  logic               rst_ni,
  // from the divider
  input  logic               res_vld_i,
  output logic               res_rdy_o,
  input  div_pkg::div_word_t res_i,
  input  div_pkg::div_tag_t  tag_i,
  // toward writeback
  output logic               wb_vld_o,
  output div_pkg::div_word_t wb_res_o,
  output div_pkg::div_tag_t  wb_tag_o,
  input  logic               wb_credit_i
);

  localparam int CNT_W = $clog2(`DIV_WB_CREDITS + 1);

  logic [CNT_W-1:0] cnt_q;
  logic             has_credit;
  logic             send;

  assign has_credit = (cnt_q != '0);
  assign res_rdy_o  = has_credit;
  assign send       = res_vld_i & has_credit;

  assign wb_vld_o = send;
  assign wb_res_o = res_i;
  assign wb_tag_o = tag_i;

  // send and return in one cycle cancel out
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_credits
    if (!rst_ni) begin
      cnt_q <= CNT_W'(`DIV_WB_CREDITS);
    end else if (send && !wb_credit_i) begin
      cnt_q <= cnt_q - 1'b1;
    end else if (!send && wb_credit_i && cnt_q != '1) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

// ==== source/div_unit.sv ====
////////////////////////////////////////
// divide unit of the execute stage
// issue queue, serial divider and
// writeback credit port in a row
////////////////////////////////////////

`timescale 1ns/1ps
`include "div_defs.svh"

module div_unit (
  input  logic               clk_i,
  input  logic               rst_ni,
  // issue side
  input  logic               issue_vld_i,
  input  div_pkg::div_op_e   issue_op_i,
  input  div_pkg::div_word_t issue_a_i,
  input  div_pkg::div_word_t issue_b_i,
  input  div_pkg::div_tag_t  issue_tag_i,
  output logic               issue_credit_o,
  // writeback side
  output logic               wb_vld_o,
  output div_pkg::div_word_t wb_res_o,
  output div_pkg::div_tag_t  wb_tag_o,
  input  logic               wb_credit_i
);

  import div_pkg::*;

  // queue head toward the divider
  logic      q_vld;
  div_op_e   q_op;
  div_word_t q_a, q_b;
  div_tag_t  q_tag;
  logic      div_rdy;

  // divider result toward writeback
  logic      div_out_vld;
  logic      div_out_rdy;
  div_word_t div_res;
  div_tag_t  div_out_tag;

  div_issue_queue i_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (issue_vld_i),
    .op_i    (issue_op_i),
    .a_i     (issue_a_i),
    .b_i     (issue_b_i),
    .tag_i   (issue_tag_i),
    .vld_o   (q_vld),
    .rdy_i   (div_rdy),
    .op_o    (q_op),
    .a_o     (q_a),
    .b_o     (q_b),
    .tag_o   (q_tag),
    .credit_o(issue_credit_o)
  );

  serdiv #(
    .WIDTH(`DIV_XLEN)
  ) i_serdiv (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .in_vld_i (q_vld),
    .in_rdy_o (div_rdy),
    .op_i     (q_op),
    .a_i      (q_a),
    .b_i      (q_b),
    .tag_i    (q_tag),
    .out_vld_o(div_out_vld),
    .out_rdy_i(div_out_rdy),
    .res_o    (div_res),
    .tag_o    (div_out_tag)
  );

  div_wb_port i_wb_port (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .res_vld_i  (div_out_vld),
    .res_rdy_o  (div_out_rdy),
    .res_i      (div_res),
    .tag_i      (div_out_tag),
    .wb_vld_o   (wb_vld_o),
    .wb_res_o   (wb_res_o),
    .wb_tag_o   (wb_tag_o),
    .wb_credit_i(wb_credit_i)
  );

endmodule

// ==== verif/tb_clk_gen.sv ====
////////////////////////////////////////
// testbench clock and reset source
// reset is released just after an edge
////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin : p_clk
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk_o = ~clk_o;
    end
  end

  // reset low for the first rising edges
  initial begin : p_rst
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2;
    rst_no = 1'b1;
  end

endmodule

// ==== verif/tb_div_unit.sv ====
////////////////////////////////////////
// testbench of the divide unit
// replays the trace file through the DUT
// under random issue gaps and wb credit delays
////////////////////////////////////////

`timescale 1ns/1ps
`include "div_defs.svh"

module tb_div_unit;

  import div_pkg::*;

  localparam int N_OPS       = 22;
  localparam int TRACE_WORDS = N_OPS * 5;
  localparam int ISSUE_DEPTH = `DIV_ISSUE_DEPTH;
  // worst case divide plus credit waits and some slack
  localparam int TIMEOUT_CYC = N_OPS * (`DIV_XLEN + 12) + 200;

  logic      clk, rst_n;
  logic      issue_vld_i;
  div_op_e   issue_op_i;
  div_word_t issue_a_i, issue_b_i;
  div_tag_t  issue_tag_i;
  logic      issue_credit_o;
  logic      wb_vld_o;
  div_word_t wb_res_o;
  div_tag_t  wb_tag_o;
  logic      wb_credit_i;

  // trace contents with five words per operation
  logic [`DIV_XLEN-1:0] trace_mem [TRACE_WORDS];
  div_op_e   op_arr  [N_OPS];
  div_word_t a_arr   [N_OPS];
  div_word_t b_arr   [N_OPS];
  div_tag_t  tag_arr [N_OPS];
  div_word_t exp_arr [N_OPS];

  // per op issue gap and wb credit hold time
  int gap_arr   [N_OPS];
  int delay_arr [N_OPS];

  // testbench side credit books
  int issue_credits = ISSUE_DEPTH;
  int wb_credits    = `DIV_WB_CREDITS;
  int n_issued      = 0;
  int n_results     = 0;
  int cyc           = 0;
  // cycle numbers at which wb credits go back
  int credit_due [$];

  tb_clk_gen #(
    .PERIOD_NS (20),
    .RST_CYCLES(2)
  ) i_clk_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  div_unit dut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .issue_vld_i   (issue_vld_i),
    .issue_op_i    (issue_op_i),
    .issue_a_i     (issue_a_i),
    .issue_b_i     (issue_b_i),
    .issue_tag_i   (issue_tag_i),
    .issue_credit_o(issue_credit_o),
    .wb_vld_o      (wb_vld_o),
    .wb_res_o      (wb_res_o),
    .wb_tag_o      (wb_tag_o),
    .wb_credit_i   (wb_credit_i)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("*** FAILED ***");
    $fatal(1, "%s", why);
  endtask

  task automatic check_result(input div_word_t exp, input div_word_t act, input int idx);
    if (act !== exp) begin
      $display("** Error at %0t: wb_res_o expected %08h actual %08h (trace op %0d)",
               $time, exp, act, idx);
      abort_run("result mismatch");
    end
  endtask

  task automatic check_tag(input div_tag_t exp, input div_tag_t act, input int idx);
    if (act !== exp) begin
      $display("** Error at %0t: wb_tag_o expected %0h actual %0h (trace op %0d)",
               $time, exp, act, idx);
      abort_run("tag mismatch");
    end
  endtask

  task automatic load_trace();
    $readmemh("verif/div_trace.txt", trace_mem);
    for (int i = 0; i < N_OPS; i++) begin
      if ($isunknown(trace_mem[i * 5 + 4])) begin
        $display("trace file is missing or holds fewer than %0d operations", N_OPS);
        abort_run("bad trace file");
      end else begin
        op_arr[i]  = div_op_e'(trace_mem[i * 5][1:0]);
        a_arr[i]   = trace_mem[i * 5 + 1];
        b_arr[i]   = trace_mem[i * 5 + 2];
        tag_arr[i] = div_tag_t'(trace_mem[i * 5 + 3]);
        exp_arr[i] = trace_mem[i * 5 + 4];
      end
    end
  endtask

  // first ops go back to back to drain every issue credit
  function automatic int issue_gap(input int idx);
    if (idx < 2 * ISSUE_DEPTH) begin
      return 0;
    end
    if ($urandom_range(0, 2) == 0) begin
      return $urandom_range(1, 5);
    end
    return 0;
  endfunction

  // mostly short delays with an occasional long hold
  function automatic int credit_delay();
    if ($urandom_range(0, 4) == 0) begin
      return $urandom_range(10, 24);
    end
    return $urandom_range(0, 6);
  endfunction

  ////////////////////////////////////////
  // issuer, writeback sink, monitor
  ////////////////////////////////////////

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  initial begin : issuer
    @(posedge rst_n);
    @(posedge clk);
    #2;
    for (int i = 0; i < N_OPS; i++) begin
      repeat (gap_arr[i]) begin
        @(posedge clk);
        #2;
      end
      // the credit count is the only flow control toward the queue
      while (issue_credits == 0) begin
        @(posedge clk);
        #2;
      end
      issue_vld_i = 1'b1;
      issue_op_i  = op_arr[i];
      issue_a_i   = a_arr[i];
      issue_b_i   = b_arr[i];
      issue_tag_i = tag_arr[i];
      issue_credits--;
      n_issued++;
      @(posedge clk);
      #2;
      issue_vld_i = 1'b0;
    end
  end

  // one credit pulse per cycle at most
  initial begin : wb_sink
    int idx;
    forever begin
      @(posedge clk);
      #2;
      idx = -1;
      foreach (credit_due[k]) begin
        if (idx < 0 && credit_due[k] <= cyc) begin
          idx = k;
        end
      end
      if (idx >= 0) begin
        credit_due.delete(idx);
        wb_credit_i = 1'b1;
        wb_credits++;
      end else begin
        wb_credit_i = 1'b0;
      end
    end
  end

  // outputs sampled mid cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (issue_credit_o) begin
        if (issue_credits >= ISSUE_DEPTH) begin
          $display("issue credit returned at %0t with no entry outstanding", $time);
          abort_run("extra issue credit");
        end
        issue_credits++;
      end
      if (wb_vld_o) begin
        if (wb_credits == 0) begin
          $display("result sent at %0t without a writeback credit", $time);
          abort_run("writeback credit violation");
        end
        if (n_results >= N_OPS) begin
          $display("result at %0t after all %0d results were seen", $time, N_OPS);
          abort_run("extra result");
        end
        wb_credits--;
        // results come back in issue order so result n is trace op n
        check_result(exp_arr[n_results], wb_res_o, n_results);
        check_tag(tag_arr[n_results], wb_tag_o, n_results);
        credit_due.push_back(cyc + 1 + delay_arr[n_results]);
        n_results++;
      end
    end
  end

  ////////////////////////////////////////
  // run control
  ////////////////////////////////////////

  initial begin : main
    bit finished;
    void'($urandom(21));
    issue_vld_i = 1'b0;
    issue_op_i  = OP_UDIV;
    issue_a_i   = '0;
    issue_b_i   = '0;
    issue_tag_i = '0;
    wb_credit_i = 1'b0;
    load_trace();
    for (int i = 0; i < N_OPS; i++) begin
      gap_arr[i]   = issue_gap(i);
      delay_arr[i] = credit_delay();
    end
    finished = 1'b0;
    while (!finished && cyc < TIMEOUT_CYC) begin
      @(posedge clk);
      #1;
      finished = (n_results == N_OPS) && (n_issued == N_OPS) &&
                 (issue_credits == ISSUE_DEPTH);
    end
    if (!finished) begin
      $display("run hung: %0d of %0d results after %0d cycles", n_results, N_OPS, cyc);
      abort_run("timeout");
    end else begin
      // a few idle cycles to catch stray results or credits
      repeat (10) @(posedge clk);
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// ==== vlog.f ====
+incdir+source
source/div_pkg.sv
source/lzc.sv
source/div_issue_queue.sv
source/serdiv.sv
source/div_wb_port.sv
source/div_unit.sv
verif/tb_clk_gen.sv
verif/tb_div_unit.sv

// ==== Bender.yml ====
package:
  name: div_unit

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/div_pkg.sv
      - source/lzc.sv
      - source/div_issue_queue.sv
      - source/serdiv.sv
      - source/div_wb_port.sv
      - source/div_unit.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_div_unit.sv

// ==== verif/div_trace.txt ====
// op a b tag expected, all in hex
// op 0 udiv, 1 div, 2 urem, 3 rem
0 00000064 00000007 1 0000000e
2 00000064 00000007 2 00000002
0 00000005 00000009 3 00000000
2 00000005 00000009 4 00000005
0 ffffffff 00000010 5 0fffffff
2 ffffffff 00000010 6 0000000f
1 00000014 00000003 7 00000006
1 ffffffec 00000003 8 fffffffa
1 00000014 fffffffd 9 fffffffa
1 ffffffec fffffffd a 00000006
3 00000014 00000003 b 00000002
3 ffffffec 00000003 c fffffffe
3 00000014 fffffffd d 00000002
3 ffffffec fffffffd e fffffffe
0 12345678 00000000 f ffffffff
2 12345678 00000000 0 12345678
1 80000000 ffffffff 1 80000000
3 80000000 ffffffff 2 00000000
1 fffffff9 00000000 3 ffffffff
3 fffffff9 00000000 4 fffffff9
0 deadbeef 00001234 5 000c3ba5
2 deadbeef 00001234 6 0000076b
